// ==== design/fm_chip_pkg.sv ====
// chip dimensions of the fm register interface
// channel and operator counts, scan length
// field widths of the synthesis parameters

package fm_chip_pkg;

    // channel layout
    localparam int NUM_CH   = 6;
    localparam int NUM_OP   = 4;
    localparam int NUM_SLOT = NUM_CH * NUM_OP; // one round of the scanner

    // per-channel frequency fields
    localparam int fnum_w  = 11;
    localparam int block_w = 3;  // octave

    // per-operator level field
    localparam int tl_w = 7;

endpackage

// ==== design/fm_reg_pkg.sv ====
// register map of the fm register interface
// global register numbers
// upper-nibble groups of the channel and operator registers
// register number union, raw byte or group/op/ch fields

package fm_reg_pkg;

    // global registers, bank 0 numbering
    localparam logic [7:0] reg_testym = 8'h21;
    localparam logic [7:0] reg_clka1  = 8'h24; // timer a, upper 8 bits
    localparam logic [7:0] reg_clka2  = 8'h25; // timer a, lower 2 bits
    localparam logic [7:0] reg_clkb   = 8'h26;
    localparam logic [7:0] reg_timer  = 8'h27; // load, flag enable, flag clear
    localparam logic [7:0] reg_kon    = 8'h28;
    localparam logic [7:0] reg_clk_n6 = 8'h2D;
    localparam logic [7:0] reg_clk_n3 = 8'h2E;
    localparam logic [7:0] reg_clk_n2 = 8'h2F;

    // register groups in bits 7:4
    localparam logic [3:0] grp_dt_mul  = 4'h3;
    localparam logic [3:0] grp_tl      = 4'h4;
    // A0 and A4 share a group, bits 3:2 tell them apart
    localparam logic [3:0] grp_fnum_lo = 4'hA;
    localparam logic [3:0] grp_fnum_hi = 4'hA;
    localparam logic [3:0] grp_fb_alg  = 4'hB;

    // one register number seen two ways
    typedef union packed {
        logic [7:0] raw;         // compared against global numbers
        struct packed {
            logic [3:0] group;
            logic [1:0] op;      // 0=S1 1=S3 2=S2 3=S4
            logic [1:0] ch;      // 3 is not a channel
        } slot;
    } reg_num_u;

endpackage

// ==== design/fm_cen_div.sv ====
// synth clock-enable divider
// counts cen pulses up to a selectable limit
// clk_en marks the last cen pulse of each period

`timescale 1ns/1ps

module fm_cen_div (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [2:0] ratio_lim, // divide ratio minus one
    output logic       clk_en
);

    logic [2:0] cen_cnt;
    logic       at_lim;

    // >= so a smaller limit written mid-count still wraps at once
    assign at_lim = cen_cnt >= ratio_lim;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= 3'd0;
        end else if (cen) begin
            if (at_lim) begin
                cen_cnt <= 3'd0;
            end else begin
                cen_cnt <= cen_cnt + 3'd1;
            end
        end
    end

    assign clk_en = cen & at_lim; // one clock wide, only in cen cycles

endmodule

// ==== design/fm_reg_bank.sv ====
// channel and operator parameter storage
// shared frequency high-byte latch
// key-on bits per slot
// slot scanner selecting one channel/operator per synth cycle

`timescale 1ns/1ps

module fm_reg_bank import fm_chip_pkg::*, fm_reg_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               clk_en,
    input  logic               up_dt_mul,
    input  logic               up_tl,
    input  logic               up_fnum_lo,
    input  logic               up_fnum_hi,
    input  logic               up_fb_alg,
    input  logic               up_keyon,
    input  logic [7:0]         wr_data,
    input  logic [2:0]         wr_ch,
    input  logic [1:0]         wr_op,
    output logic [2:0]         slot_ch,
    output logic [1:0]         slot_op,
    output logic [fnum_w-1:0]  fnum,
    output logic [block_w-1:0] block,
    output logic [2:0]         fb,
    output logic [2:0]         alg,
    output logic [2:0]         dt1,
    output logic [3:0]         mul,
    output logic [tl_w-1:0]    tl,
    output logic               keyon
);

    // per channel
    logic [fnum_w-1:0]  fnum_q  [NUM_CH];
    logic [block_w-1:0] block_q [NUM_CH];
    logic [2:0]         fb_q    [NUM_CH];
    logic [2:0]         alg_q   [NUM_CH];
    // per operator, index op*NUM_CH+ch
    logic [2:0]         dt1_q   [NUM_SLOT];
    logic [3:0]         mul_q   [NUM_SLOT];
    logic [tl_w-1:0]    tl_q    [NUM_SLOT];
    logic [NUM_SLOT-1:0] keyon_q;

    logic [5:0] latch_fnum; // one latch for all channels
    logic [4:0] wr_idx;
    logic [4:0] slot_idx;

    // key-on byte: key bits on top, channel code below
    reg_num_u   kon_byte;
    logic [2:0] kon_ch;
    logic       kon_valid;
    logic [3:0] kon_ops;

    assign wr_idx   = 5'(wr_op) * 5'(NUM_CH) + 5'(wr_ch);
    assign slot_idx = 5'(slot_op) * 5'(NUM_CH) + 5'(slot_ch);

    assign kon_byte.raw = wr_data;
    assign kon_ch    = kon_byte.slot.op[0] ? 3'(NUM_CH / 2) + {1'b0, kon_byte.slot.ch}
                                           : {1'b0, kon_byte.slot.ch};
    assign kon_valid = kon_byte.slot.ch != 2'd3;
    // bits 4..7 are S1,S2,S3,S4; op codes run S1,S3,S2,S4
    assign kon_ops = {kon_byte.slot.group[3], kon_byte.slot.group[1],
                      kon_byte.slot.group[2], kon_byte.slot.group[0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                fnum_q[c]  <= '0;
                block_q[c] <= '0;
                fb_q[c]    <= '0;
                alg_q[c]   <= '0;
            end
            for (int s = 0; s < NUM_SLOT; s++) begin
                dt1_q[s] <= '0;
                mul_q[s] <= '0;
                tl_q[s]  <= '0;
            end
            keyon_q    <= '0;
            latch_fnum <= '0;
        end else begin
            if (up_fnum_hi) latch_fnum <= wr_data[5:0];
            if (up_fnum_lo) {block_q[wr_ch], fnum_q[wr_ch]} <= {latch_fnum, wr_data};
            if (up_fb_alg) begin
                fb_q[wr_ch]  <= wr_data[5:3];
                alg_q[wr_ch] <= wr_data[2:0];
            end
            if (up_dt_mul) begin
                dt1_q[wr_idx] <= wr_data[6:4];
                mul_q[wr_idx] <= wr_data[3:0];
            end
            if (up_tl) tl_q[wr_idx] <= wr_data[tl_w-1:0];
            if (up_keyon && kon_valid) begin
                for (int o = 0; o < NUM_OP; o++) begin
                    keyon_q[o * NUM_CH + int'(kon_ch)] <= kon_ops[o];
                end
            end
        end
    end

    // channels within an op, then the next op
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_ch <= 3'd0;
            slot_op <= 2'd0;
        end else if (clk_en) begin
            if (slot_ch == 3'(NUM_CH - 1)) begin
                slot_ch <= 3'd0;
                slot_op <= (slot_op == 2'(NUM_OP - 1)) ? 2'd0 : slot_op + 2'd1;
            end else begin
                slot_ch <= slot_ch + 3'd1;
            end
        end
    end

    assign fnum  = fnum_q[slot_ch];
    assign block = block_q[slot_ch];
    assign fb    = fb_q[slot_ch];
    assign alg   = alg_q[slot_ch];
    assign dt1   = dt1_q[slot_idx];
    assign mul   = mul_q[slot_idx];
    assign tl    = tl_q[slot_idx];
    assign keyon = keyon_q[slot_idx];

endmodule

// ==== design/fm_mmr.sv ====
// host side of the fm register interface
// address latch and register decoding
// timer and divider-ratio registers
// busy counter and one-clock update strobes
// contains the clock-enable divider and the register bank

`timescale 1ns/1ps

module fm_mmr import fm_chip_pkg::*, fm_reg_pkg::*; #(
    parameter int BUSY_LEN = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               write,
    input  logic [7:0]         din,
    input  logic [1:0]         addr,
    output logic               clk_en,
    output logic               busy,
    output logic [9:0]         value_a,
    output logic [7:0]         value_b,
    output logic               load_a,
    output logic               load_b,
    output logic               en_flag_a,
    output logic               en_flag_b,
    output logic               clr_flag_a,
    output logic               clr_flag_b,
    output logic [2:0]         slot_ch,
    output logic [1:0]         slot_op,
    output logic [fnum_w-1:0]  fnum,
    output logic [block_w-1:0] block,
    output logic [2:0]         fb,
    output logic [2:0]         alg,
    output logic [2:0]         dt1,
    output logic [3:0]         mul,
    output logic [tl_w-1:0]    tl,
    output logic               keyon
);

    reg_num_u   sel_reg;     // last register number written
    logic [2:0] ratio_lim;
    logic       old_write;
    logic [4:0] busy_cnt;
    logic       data_wr;
    logic [2:0] target_ch;

    logic dec_dt_mul, dec_tl, dec_fnum_lo, dec_fnum_hi, dec_fb_alg, dec_keyon;

    // held write for the bank
    logic [7:0] data_q;
    logic [2:0] data_ch;
    logic [1:0] data_op;
    logic up_dt_mul, up_tl, up_fnum_lo, up_fnum_hi, up_fb_alg, up_keyon;

    assign data_wr = write & addr[0];

    // addr[1] picks channels 3..5
    assign target_ch = addr[1] ? 3'(NUM_CH / 2) + {1'b0, sel_reg.slot.ch}
                               : {1'b0, sel_reg.slot.ch};

    always_comb begin
        dec_dt_mul  = 1'b0;
        dec_tl      = 1'b0;
        dec_fnum_lo = 1'b0;
        dec_fnum_hi = 1'b0;
        dec_fb_alg  = 1'b0;
        dec_keyon   = sel_reg.raw == reg_kon;
        if (sel_reg.slot.ch != 2'd3) begin // no fourth channel per bank
            dec_dt_mul  = sel_reg.slot.group == grp_dt_mul;
            dec_tl      = sel_reg.slot.group == grp_tl;
            dec_fnum_lo = sel_reg.slot.group == grp_fnum_lo && sel_reg.slot.op == 2'd0;
            dec_fnum_hi = sel_reg.slot.group == grp_fnum_hi && sel_reg.slot.op == 2'd1;
            dec_fb_alg  = sel_reg.slot.group == grp_fb_alg && sel_reg.slot.op == 2'd0;
        end
    end

    // global registers, written on the sampling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg.raw <= 8'h00;
            ratio_lim   <= 3'd5;   // divide by 6
            value_a     <= '0;
            value_b     <= '0;
            {clr_flag_b, clr_flag_a, en_flag_b, en_flag_a, load_b, load_a} <= 6'd0;
        end else if (write) begin
            if (!addr[0]) begin
                sel_reg.raw <= din;
            end else begin
                case (sel_reg.raw)
                    reg_testym: ;                      // test bits not kept
                    reg_clka1:  value_a[9:2] <= din;
                    reg_clka2:  value_a[1:0] <= din[1:0];
                    reg_clkb:   value_b      <= din;
                    reg_timer: begin
                        {clr_flag_b, clr_flag_a, en_flag_b, en_flag_a, load_b, load_a}
                            <= din[5:0];
                    end
                    reg_clk_n6: ratio_lim <= 3'd5;
                    reg_clk_n3: ratio_lim <= 3'd2;
                    reg_clk_n2: ratio_lim <= 3'd1;
                    default: ;
                endcase
            end
        end else if (clk_en) begin
            // flag clears last until the next synth cycle
            clr_flag_a <= 1'b0;
            clr_flag_b <= 1'b0;
        end
    end

    // strobes one clock after the data write
    always_ff @(posedge clk) begin
        if (rst) begin
            up_dt_mul  <= 1'b0;
            up_tl      <= 1'b0;
            up_fnum_lo <= 1'b0;
            up_fnum_hi <= 1'b0;
            up_fb_alg  <= 1'b0;
            up_keyon   <= 1'b0;
        end else begin
            up_dt_mul  <= data_wr & dec_dt_mul;
            up_tl      <= data_wr & dec_tl;
            up_fnum_lo <= data_wr & dec_fnum_lo;
            up_fnum_hi <= data_wr & dec_fnum_hi;
            up_fb_alg  <= data_wr & dec_fb_alg;
            up_keyon   <= data_wr & dec_keyon;
        end
    end

    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_q  <= din;
            data_ch <= target_ch;
            data_op <= sel_reg.slot.op;
        end
    end

    // busy counts synth cycles from the rising edge of a data write
    always_ff @(posedge clk) begin
        if (rst) begin
            old_write <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= 5'd0;
        end else begin
            old_write <= write;
            if (!old_write && data_wr) begin
                busy     <= 1'b1;
                busy_cnt <= 5'd0;
            end else if (clk_en && busy) begin
                if (busy_cnt == 5'(BUSY_LEN - 1)) begin
                    busy <= 1'b0;
                end
                busy_cnt <= busy_cnt + 5'd1;
            end
        end
    end

    fm_cen_div cen_div_i (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .ratio_lim (ratio_lim),
        .clk_en    (clk_en)
    );

    fm_reg_bank reg_bank_i (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .up_dt_mul  (up_dt_mul),
        .up_tl      (up_tl),
        .up_fnum_lo (up_fnum_lo),
        .up_fnum_hi (up_fnum_hi),
        .up_fb_alg  (up_fb_alg),
        .up_keyon   (up_keyon),
        .wr_data    (data_q),
        .wr_ch      (data_ch),
        .wr_op      (data_op),
        .slot_ch    (slot_ch),
        .slot_op    (slot_op),
        .fnum       (fnum),
        .block      (block),
        .fb         (fb),
        .alg        (alg),
        .dt1        (dt1),
        .mul        (mul),
        .tl         (tl),
        .keyon      (keyon)
    );

endmodule

// ==== design/fm_timers.sv ====
// timer a (10 bit) and timer b (8 bit)
// reloadable up-counters on the synth clock enable
// timer b prescaler of 16 synth cycles
// overflow flags and active-low interrupt

`timescale 1ns/1ps

module fm_timers (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  logic [9:0] value_a,
    input  logic [7:0] value_b,
    input  logic       load_a,
    input  logic       load_b,
    input  logic       en_flag_a,
    input  logic       en_flag_b,
    input  logic       clr_flag_a,
    input  logic       clr_flag_b,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [3:0] pre_b;  // free running
    logic       tick_b;

    assign tick_b = clk_en && pre_b == 4'hF;

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_b <= 4'd0;
        end else if (clk_en) begin
            pre_b <= pre_b + 4'd1;
        end
    end

    // counter sits at the reload value until load goes high
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a  <= 10'd0;
            flag_a <= 1'b0;
        end else begin
            if (!load_a) begin
                cnt_a <= value_a;
            end else if (clk_en) begin
                cnt_a <= (cnt_a == 10'h3FF) ? value_a : cnt_a + 10'd1;
            end
            if (clr_flag_a) flag_a <= 1'b0;
            else if (load_a && clk_en && cnt_a == 10'h3FF && en_flag_a) flag_a <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_b  <= 8'd0;
            flag_b <= 1'b0;
        end else begin
            if (!load_b) begin
                cnt_b <= value_b;
            end else if (tick_b) begin
                cnt_b <= (cnt_b == 8'hFF) ? value_b : cnt_b + 8'd1;
            end
            if (clr_flag_b) flag_b <= 1'b0;
            else if (load_b && tick_b && cnt_b == 8'hFF && en_flag_b) flag_b <= 1'b1;
        end
    end

    assign irq_n = ~(flag_a | flag_b);

endmodule

// ==== design/fm_regs_top.sv ====
// top level of the fm register interface
// host register block with divider, bank and busy
// timers a and b with interrupt

`timescale 1ns/1ps

module fm_regs_top import fm_chip_pkg::*; #(
    parameter int BUSY_LEN = 32 // synth cycles of busy per data write
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               write,
    input  logic [7:0]         din,
    input  logic [1:0]         addr,
    output logic               busy,
    output logic               clk_en,
    output logic               irq_n,
    output logic               flag_a,
    output logic               flag_b,
    output logic [2:0]         slot_ch,
    output logic [1:0]         slot_op,
    output logic [fnum_w-1:0]  fnum,
    output logic [block_w-1:0] block,
    output logic [2:0]         fb,
    output logic [2:0]         alg,
    output logic [2:0]         dt1,
    output logic [3:0]         mul,
    output logic [tl_w-1:0]    tl,
    output logic               keyon
);

    logic [9:0] value_a;
    logic [7:0] value_b;
    logic load_a, load_b;
    logic en_flag_a, en_flag_b;
    logic clr_flag_a, clr_flag_b;

    fm_mmr #(
        .BUSY_LEN (BUSY_LEN)
    ) mmr_i (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .write      (write),
        .din        (din),
        .addr       (addr),
        .clk_en     (clk_en),
        .busy       (busy),
        .value_a    (value_a),
        .value_b    (value_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .en_flag_a  (en_flag_a),
        .en_flag_b  (en_flag_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .slot_ch    (slot_ch),
        .slot_op    (slot_op),
        .fnum       (fnum),
        .block      (block),
        .fb         (fb),
        .alg        (alg),
        .dt1        (dt1),
        .mul        (mul),
        .tl         (tl),
        .keyon      (keyon)
    );

    fm_timers timers_i (
        .clk        (clk),
        .rst        (rst),
        .clk_en     (clk_en),
        .value_a    (value_a),
        .value_b    (value_b),
        .load_a     (load_a),
        .load_b     (load_b),
        .en_flag_a  (en_flag_a),
        .en_flag_b  (en_flag_b),
        .clr_flag_a (clr_flag_a),
        .clr_flag_b (clr_flag_b),
        .flag_a     (flag_a),
        .flag_b     (flag_b),
        .irq_n      (irq_n)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
// testbench clock and reset generator
// free running clock, synchronous reset held for a few cycles

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;  // released just after the edge, like the other inputs
    end

endmodule

// ==== test/fm_regs_top_tb.sv ====
// testbench for the fm register interface
// random register, key-on, divider and timer writes
// parameter model checked against the slot outputs every idle cycle
// busy length, divider ratio and timer overflow checks with a run timeout

`timescale 1ns/1ps

module fm_regs_top_tb import fm_chip_pkg::*; ();

    // about 13k cycles of writes plus 3k for timer a and 11k for timer b
    localparam int timeout_cycles = 40000;
    localparam int n_param_wr     = 20;
    localparam int n_kon_wr       = 10;

    logic               clk;
    logic               rst;
    logic               cen;
    logic               write;
    logic [7:0]         din;
    logic [1:0]         addr;
    logic               busy;
    logic               clk_en;
    logic               irq_n;
    logic               flag_a;
    logic               flag_b;
    logic [2:0]         slot_ch;
    logic [1:0]         slot_op;
    logic [fnum_w-1:0]  fnum;
    logic [block_w-1:0] block;
    logic [2:0]         fb;
    logic [2:0]         alg;
    logic [2:0]         dt1;
    logic [3:0]         mul;
    logic [tl_w-1:0]    tl;
    logic               keyon;

    // reference model with operator entries at op*NUM_CH+ch
    logic [fnum_w-1:0]  m_fnum  [NUM_CH];
    logic [block_w-1:0] m_block [NUM_CH];
    logic [2:0]         m_fb    [NUM_CH];
    logic [2:0]         m_alg   [NUM_CH];
    logic [2:0]         m_dt1   [NUM_SLOT];
    logic [3:0]         m_mul   [NUM_SLOT];
    logic [tl_w-1:0]    m_tl    [NUM_SLOT];
    logic               m_kon   [NUM_SLOT];
    logic [5:0]         m_latch;            // shared high byte
    logic [2:0]         exp_ch;
    logic [1:0]         exp_op;

    int    cycles = 0;
    int    seed_ret;
    string test_name;

    tb_clk_gen #(
        .PERIOD     (20),
        .RST_CYCLES (3)
    ) clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    fm_regs_top fm_regs_top_i (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .write   (write),
        .din     (din),
        .addr    (addr),
        .busy    (busy),
        .clk_en  (clk_en),
        .irq_n   (irq_n),
        .flag_a  (flag_a),
        .flag_b  (flag_b),
        .slot_ch (slot_ch),
        .slot_op (slot_op),
        .fnum    (fnum),
        .block   (block),
        .fb      (fb),
        .alg     (alg),
        .dt1     (dt1),
        .mul     (mul),
        .tl      (tl),
        .keyon   (keyon)
    );

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input int want, input int got);
        report_error($sformatf("ERR %s %s: expected %0h, actual %0h", test_name, what, want, got));
    endtask

    // cen high about 3 cycles in 4
    always @(posedge clk) begin
        #2;
        cen = ($urandom % 4) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            report_error($sformatf("run did not finish within %0d cycles", cycles));
        end
    end

    task automatic check_slot_params();
        int c;
        int s;
        c = slot_ch;
        s = slot_op * NUM_CH + slot_ch;
        assert (fnum == m_fnum[c]) else report_mismatch($sformatf("fnum ch%0d", c), m_fnum[c], fnum);
        assert (block == m_block[c])
            else report_mismatch($sformatf("block ch%0d", c), m_block[c], block);
        assert (fb == m_fb[c]) else report_mismatch($sformatf("fb ch%0d", c), m_fb[c], fb);
        assert (alg == m_alg[c]) else report_mismatch($sformatf("alg ch%0d", c), m_alg[c], alg);
        assert (dt1 == m_dt1[s]) else report_mismatch($sformatf("dt1 slot%0d", s), m_dt1[s], dt1);
        assert (mul == m_mul[s]) else report_mismatch($sformatf("mul slot%0d", s), m_mul[s], mul);
        assert (tl == m_tl[s]) else report_mismatch($sformatf("tl slot%0d", s), m_tl[s], tl);
        assert (keyon == m_kon[s])
            else report_mismatch($sformatf("keyon slot%0d", s), m_kon[s], keyon);
    endtask

    // scanner order and stored parameters sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            exp_ch = 3'd0;
            exp_op = 2'd0;
        end else begin
            assert (slot_ch == exp_ch && slot_op == exp_op)
                else report_mismatch("slot scan", {exp_op, exp_ch}, {slot_op, slot_ch});
            if (!busy) check_slot_params();
            if (clk_en) begin
                if (exp_ch == NUM_CH - 1) begin
                    exp_ch = 3'd0;
                    exp_op = exp_op + 2'd1;  // wraps after op 3
                end else begin
                    exp_ch = exp_ch + 3'd1;
                end
            end
        end
    end

    // register number on the even address and data on the odd one
    task automatic host_write(input logic bank, input logic [7:0] num, input logic [7:0] data);
        @(posedge clk);
        #2;
        write = 1'b1;
        addr  = {bank, 1'b0};
        din   = num;
        @(posedge clk);
        #2;
        write = 1'b0;       // write must toggle for busy
        @(posedge clk);
        #2;
        write = 1'b1;
        addr  = {bank, 1'b1};
        din   = data;
        @(posedge clk);
        #2;
        write = 1'b0;
    endtask

    task automatic wait_busy_check();
        int n;
        n = 0;
        @(negedge clk);
        assert (busy) else report_error("busy did not rise after a data write");
        while (busy) begin
            if (clk_en) n++;
            @(negedge clk);
        end
        assert (n == fm_regs_top_i.BUSY_LEN)
            else report_mismatch("busy length", fm_regs_top_i.BUSY_LEN, n);
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);
    endtask

    task automatic param_writes();
        logic       bank;
        logic [1:0] code;
        logic [1:0] op;
        logic [7:0] data;
        int         kind;
        int         ch;
        int         s;
        test_name = "param write";
        for (int i = 0; i < n_param_wr; i++) begin
            bank = $urandom;
            code = $urandom;  // 3 is not a channel
            op   = $urandom;
            data = $urandom;
            kind = $urandom % 4;
            ch   = bank * 3 + code;
            s    = op * NUM_CH + ch;
            case (kind)
                0: begin
                    host_write(bank, {4'h3, op, code}, data);
                    if (code != 2'd3) begin
                        m_dt1[s] = data[6:4];
                        m_mul[s] = data[3:0];
                    end
                end
                1: begin
                    host_write(bank, {4'h4, op, code}, data);
                    if (code != 2'd3) m_tl[s] = data[6:0];
                end
                2: begin
                    host_write(bank, {4'hA, 2'd1, code}, data);
                    if (code != 2'd3) m_latch = data[5:0];
                    wait_busy_check();
                    // low byte often goes to another channel
                    if ($urandom % 2) begin
                        bank = $urandom;
                        code = $urandom;
                        ch   = bank * 3 + code;
                    end
                    data = $urandom;
                    host_write(bank, {4'hA, 2'd0, code}, data);
                    if (code != 2'd3) begin
                        m_block[ch] = m_latch[5:3];
                        m_fnum[ch]  = {m_latch[2:0], data};
                    end
                end
                default: begin
                    host_write(bank, {4'hB, 2'd0, code}, data);
                    if (code != 2'd3) begin
                        m_fb[ch]  = data[5:3];
                        m_alg[ch] = data[2:0];
                    end
                end
            endcase
            wait_busy_check();
        end
    endtask

    task automatic keyon_writes();
        logic [7:0] data;
        int         ch;
        test_name = "key-on";
        for (int i = 0; i < n_kon_wr; i++) begin
            data = $urandom;
            if (i % 4 == 3) data[2:0] = 3'(i);  // codes 3 and 7
            host_write(1'b0, 8'h28, data);
            if (data[1:0] != 2'b11) begin
                ch = data[2] * 3 + data[1:0];
                m_kon[0 * NUM_CH + ch] = data[4];   // S1
                m_kon[1 * NUM_CH + ch] = data[6];   // op 1 is S3
                m_kon[2 * NUM_CH + ch] = data[5];   // op 2 is S2
                m_kon[3 * NUM_CH + ch] = data[7];
            end
            wait_busy_check();
        end
    endtask

    task automatic divider_check(input logic [7:0] num, input int ratio);
        int n;
        test_name = $sformatf("divider %0d", ratio);
        host_write(1'b0, num, 8'h00);
        wait_busy_check();
        do begin
            @(negedge clk);
        end while (!clk_en);
        repeat (4) begin
            n = 0;
            do begin
                @(negedge clk);
                if (cen) n++;
            end while (!clk_en);
            assert (n == ratio) else report_mismatch("cen cycles per clk_en", ratio, n);
        end
    endtask

    task automatic timer_a_check();
        logic [9:0] va;
        int         want;
        int         n;
        test_name = "timer a";
        va   = $urandom;
        want = 1024 - va;
        host_write(1'b0, 8'h24, va[9:2]);
        wait_busy_check();
        host_write(1'b0, 8'h25, {6'd0, va[1:0]});
        wait_busy_check();
        host_write(1'b0, 8'h27, 8'h05);  // load and flag enable for timer a
        n = 0;
        @(negedge clk);
        while (!flag_a && n <= want + 1) begin
            if (clk_en) n++;
            @(negedge clk);
        end
        assert (flag_a) else report_error("flag_a did not set after the timer a overflow");
        assert (n >= want - 1 && n <= want + 1) else report_mismatch("clk_en to flag_a", want, n);
        assert (!irq_n) else report_error("irq_n stayed high while flag_a was set");
        wait_idle();
        host_write(1'b0, 8'h27, 8'h10);  // clear flag a and stop the timer
        wait_busy_check();
        assert (!flag_a && irq_n) else report_error("flag_a or irq_n did not clear");
    endtask

    task automatic timer_b_check();
        logic [7:0] vb;
        int         want;
        int         n;
        test_name = "timer b";
        vb   = $urandom % 16;
        want = 16 * (256 - vb);
        host_write(1'b0, 8'h26, vb);
        wait_busy_check();
        host_write(1'b0, 8'h27, 8'h0A);  // load and flag enable for timer b
        n = 0;
        @(negedge clk);
        while (!flag_b && n <= want) begin
            if (clk_en) n++;
            @(negedge clk);
        end
        assert (flag_b) else report_error("flag_b did not set after the timer b overflow");
        // prescaler phase at load moves the flag by up to 15 pulses
        assert (n >= want - 15 && n <= want) else report_mismatch("clk_en to flag_b", want, n);
        assert (!irq_n) else report_error("irq_n stayed high while flag_b was set");
        wait_idle();
        host_write(1'b0, 8'h27, 8'h20);
        wait_busy_check();
        assert (!flag_b && irq_n) else report_error("flag_b or irq_n did not clear");
    endtask

    initial begin
        seed_ret = $urandom(32'h84aa);
        cen      = 1'b0;
        write    = 1'b0;
        din      = 8'h00;
        addr     = 2'b00;
        m_latch  = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            m_fnum[c]  = '0;
            m_block[c] = '0;
            m_fb[c]    = '0;
            m_alg[c]   = '0;
        end
        for (int s = 0; s < NUM_SLOT; s++) begin
            m_dt1[s] = '0;
            m_mul[s] = '0;
            m_tl[s]  = '0;
            m_kon[s] = 1'b0;
        end
        test_name = "reset";
        wait (rst === 1'b0);
        @(negedge clk);
        assert (!busy && irq_n && !flag_a && !flag_b)
            else report_error("busy, flags or irq_n not at their reset values");
        param_writes();
        keyon_writes();
        // divide by 3 first so the 2D write has to change the ratio
        divider_check(8'h2E, 3);
        divider_check(8'h2D, 6);
        divider_check(8'h2F, 2);  // timers run at the fast ratio
        timer_a_check();
        timer_b_check();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== fm_regs_top.f ====
design/fm_chip_pkg.sv
design/fm_reg_pkg.sv
design/fm_cen_div.sv
design/fm_reg_bank.sv
design/fm_mmr.sv
design/fm_timers.sv
design/fm_regs_top.sv
test/tb_clk_gen.sv
test/fm_regs_top_tb.sv
